// File: sim/hzd_tb.sv
/* Testbench for the back-end dispatch control
   Replays per-cycle vectors from a file and checks dispatch, roll and poison */
`timescale 1ns/1ps
`default_nettype none

module hzd_tb;

   localparam int clk_period_lp   = 8;
   localparam int reset_cycles_lp = 5;
   localparam int slack_cycles_lp = 20;
   localparam     tests_file_lp   = "sim/hzd_tests.txt";

   // One line of the vector file
   typedef struct packed {
      logic        isd_v;
      logic [31:0] instr;
      logic [31:0] pc;
      logic [31:0] npc;
      logic        mmu_ready;
      logic        credits_full;
      logic        credits_empty;
      logic        flush;
      logic        miss;
      logic        dispatch;
      logic        roll;
      logic        poison_iss;
      logic        poison_isd;
      logic        poison_ex1;
      logic        poison_ex2;
   } vector_s;

   logic        clk_i = 1'b0;
   logic        reset_i;
   logic        isd_v_i;
   logic [31:0] isd_instr_i;
   logic [31:0] isd_pc_i;
   logic [31:0] expected_npc_i;
   logic        mmu_cmd_ready_i;
   logic        credits_full_i;
   logic        credits_empty_i;
   logic        flush_i;
   logic        mem3_miss_i;

   logic        dispatch_v_o;
   logic        roll_o;
   logic        poison_iss_o;
   logic        poison_isd_o;
   logic        poison_ex1_o;
   logic        poison_ex2_o;

   vector_s     vectors [$];
   int          cycle_cnt   = 0;
   int          cycle_limit = 0;

   hzd_backend_ctrl DUT (
      .clk_i          (clk_i),
      .reset_i        (reset_i),
      .isd_v_i        (isd_v_i),
      .isd_instr_i    (isd_instr_i),
      .isd_pc_i       (isd_pc_i),
      .expected_npc_i (expected_npc_i),
      .mmu_cmd_ready_i(mmu_cmd_ready_i),
      .credits_full_i (credits_full_i),
      .credits_empty_i(credits_empty_i),
      .flush_i        (flush_i),
      .mem3_miss_i    (mem3_miss_i),
      .dispatch_v_o   (dispatch_v_o),
      .roll_o         (roll_o),
      .poison_iss_o   (poison_iss_o),
      .poison_isd_o   (poison_isd_o),
      .poison_ex1_o   (poison_ex1_o),
      .poison_ex2_o   (poison_ex2_o)
   );

   always #(clk_period_lp / 2) clk_i = ~clk_i;

   task automatic abort_run(input string reason);
      $display("ERROR: %s", reason);
      $display("sim failed");
      $fatal(1, "Run aborted");
   endtask

   task automatic compare_value(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
      if (actual !== expected)
      begin
         $display("MISMATCH at %0t: %s expected %0h got %0h", $time, name, expected, actual);
         $display("sim failed");
         $fatal(1, "Stopping at first error");
      end
   endtask

   // Lines starting with # are comments
   task automatic load_vectors();
      int          fd;
      int          line_no;
      int          n;
      string       line;
      logic [31:0] f [15];
      vector_s     v;
      line_no = 0;
      fd = $fopen(tests_file_lp, "r");
      if (fd == 0)
      begin
         abort_run($sformatf("cannot open test vector file %s", tests_file_lp));
      end
      while ($fgets(line, fd) != 0)
      begin
         line_no++;
         if (line.len() > 1 && line.getc(0) != "#")
         begin
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7],
                        f[8], f[9], f[10], f[11], f[12], f[13], f[14]);
            if (n != 15)
            begin
               abort_run($sformatf("malformed line %0d in test vector file", line_no));
            end
            v.isd_v         = f[0][0];
            v.instr         = f[1];
            v.pc            = f[2];
            v.npc           = f[3];
            v.mmu_ready     = f[4][0];
            v.credits_full  = f[5][0];
            v.credits_empty = f[6][0];
            v.flush         = f[7][0];
            v.miss          = f[8][0];
            v.dispatch      = f[9][0];
            v.roll          = f[10][0];
            v.poison_iss    = f[11][0];
            v.poison_isd    = f[12][0];
            v.poison_ex1    = f[13][0];
            v.poison_ex2    = f[14][0];
            vectors.push_back(v);
         end
      end
      $fclose(fd);
      if (vectors.size() == 0)
      begin
         abort_run("test vector file holds no vectors");
      end
   endtask

   task automatic apply_vector(input vector_s v);
      isd_v_i         = v.isd_v;
      isd_instr_i     = v.instr;
      isd_pc_i        = v.pc;
      expected_npc_i  = v.npc;
      mmu_cmd_ready_i = v.mmu_ready;
      credits_full_i  = v.credits_full;
      credits_empty_i = v.credits_empty;
      flush_i         = v.flush;
      mem3_miss_i     = v.miss;
   endtask

   task automatic check_outputs(input vector_s v);
      compare_value("dispatch_v_o", v.dispatch, dispatch_v_o);
      compare_value("roll_o", v.roll, roll_o);
      compare_value("poison_iss_o", v.poison_iss, poison_iss_o);
      compare_value("poison_isd_o", v.poison_isd, poison_isd_o);
      compare_value("poison_ex1_o", v.poison_ex1, poison_ex1_o);
      compare_value("poison_ex2_o", v.poison_ex2, poison_ex2_o);
   endtask

   // Run limit, armed once the vector count is known
   always @(posedge clk_i)
   begin
      cycle_cnt = cycle_cnt + 1;
      if (cycle_limit > 0 && cycle_cnt > cycle_limit)
      begin
         abort_run($sformatf("timeout after %0d clock cycles", cycle_cnt));
      end
   end

   initial
   begin
      reset_i         = 1'b1;
      isd_v_i         = 1'b0;
      isd_instr_i     = '0;
      isd_pc_i        = '0;
      expected_npc_i  = '0;
      mmu_cmd_ready_i = 1'b1;
      credits_full_i  = 1'b0;
      credits_empty_i = 1'b1;
      flush_i         = 1'b0;
      mem3_miss_i     = 1'b0;

      load_vectors();
      cycle_limit = vectors.size() + reset_cycles_lp + slack_cycles_lp;

      repeat (reset_cycles_lp) @(posedge clk_i);
      #1;
      reset_i = 1'b0;

      // Drive just after the edge, sample just before the next one
      for (int i = 0; i < vectors.size(); i++)
      begin
         apply_vector(vectors[i]);
         #(clk_period_lp - 2);
         check_outputs(vectors[i]);
         @(posedge clk_i);
         #1;
      end

      $display("sim passed");
      $finish;
   end

endmodule

`default_nettype wire

// File: sim/hzd_tests.txt
# isd_v instr pc npc mmu_ready credits_full credits_empty flush mem3_miss
# then expected dispatch roll poison_iss poison_isd poison_ex1 poison_ex2, all hex
# Idle after reset
0 00000000 00000000 00000000 1 0 1 0 0 1 0 0 0 0 0
# Load x5, then add x6,x5,x7 stalls in ex1 and ex2
1 0000a283 00000100 00000000 1 0 1 0 0 1 0 0 0 0 0
1 00728333 00000104 00000100 1 0 1 0 0 0 0 0 0 0 0
1 00728333 00000104 00000104 1 0 1 0 0 0 0 0 0 0 0
1 00728333 00000104 00000104 1 0 1 0 0 1 0 0 0 0 0
# Load x5, then add x8,x0,x0 does not stall
1 0000a283 00000108 00000104 1 0 1 0 0 1 0 0 0 0 0
1 00000433 0000010c 00000108 1 0 1 0 0 1 0 0 0 0 0
# fadd f3, then fadd f4,f3,f5 stalls through ex1, ex2 and iwb
1 002081d3 00000110 0000010c 1 0 1 0 0 1 0 0 0 0 0
1 00518253 00000114 00000110 1 0 1 0 0 0 0 0 0 0 0
1 00518253 00000114 00000114 1 0 1 0 0 0 0 0 0 0 0
1 00518253 00000114 00000114 1 0 1 0 0 0 0 0 0 0 0
1 00518253 00000114 00000114 1 0 1 0 0 1 0 0 0 0 0
# mul x9, then add x10,x9,x0 stalls only in ex1
1 022084b3 00000118 00000114 1 0 1 0 0 1 0 0 0 0 0
1 00048533 0000011c 00000118 1 0 1 0 0 0 0 0 0 0 0
1 00048533 0000011c 0000011c 1 0 1 0 0 1 0 0 0 0 0
# Fence waits for credits, store waits while credits are full
1 0ff0000f 00000120 0000011c 1 0 0 0 0 0 0 0 0 0 0
1 0ff0000f 00000120 00000120 1 0 1 0 0 1 0 0 0 0 0
1 0020a423 00000124 00000120 1 1 0 0 0 0 0 0 0 0 0
1 0020a423 00000124 00000124 1 0 0 0 0 1 0 0 0 0 0
# MMU not ready with nothing at issue
0 00000000 00000128 00000124 0 0 0 0 0 0 0 0 0 0 0
# Fence waits for the store to leave iwb
1 0ff0000f 00000128 00000128 1 0 1 0 0 0 0 0 0 0 0
1 0ff0000f 00000128 00000128 1 0 1 0 0 0 0 0 0 0 0
1 0ff0000f 00000128 00000128 1 0 1 0 0 1 0 0 0 0 0
# CSR read blocks dispatch from ex1 to fwb
1 300025f3 0000012c 00000128 1 0 1 0 0 1 0 0 0 0 0
1 0000a283 00000130 0000012c 1 0 1 0 0 0 0 0 0 0 0
1 0000a283 00000130 00000130 1 0 1 0 0 0 0 0 0 0 0
1 0000a283 00000130 00000130 1 0 1 0 0 0 0 0 0 0 0
1 0000a283 00000130 00000130 1 0 1 0 0 0 0 0 0 0 0
1 0000a283 00000130 00000130 1 0 1 0 0 1 0 0 0 0 0
# Mispredict on the load in ex1 kills it, so the reader goes next cycle
1 00728333 00000134 00000200 1 0 1 0 0 0 0 1 1 1 0
1 00728333 00000134 00000134 1 0 1 0 0 1 0 0 0 0 0
# Flush, then a miss with and without an instruction at issue
0 00000000 00000138 00000134 1 0 1 1 0 1 0 1 1 1 1
0 00000000 00000138 00000138 1 0 1 0 1 1 1 1 1 1 1
1 002081d3 0000013c 00000138 1 0 1 0 1 1 1 1 1 1 1
1 00518253 00000140 0000013c 1 0 1 0 0 1 0 0 0 0 0
0 00000000 00000144 00000140 1 0 1 0 0 1 0 0 0 0 0

// File: verilog.f
verilog/hzd_pkg.sv
verilog/hzd_issue_decode.sv
verilog/hzd_dep_pipe.sv
verilog/hzd_detector.sv
verilog/hzd_backend_ctrl.sv
sim/hzd_tb.sv

// File: verilog/hzd_backend_ctrl.sv
/* Back-end dispatch control
   Ties issue decode, the dependency pipeline and the hazard detector together */
`timescale 1ns/1ps
`default_nettype none

module hzd_backend_ctrl
   import hzd_pkg::*;
   #(parameter int vaddr_width_p = 32)
   (
   input  wire                      clk_i,
   input  wire                      reset_i,
   input  wire                      isd_v_i,
   input  wire  [31:0]              isd_instr_i,
   input  wire  [vaddr_width_p-1:0] isd_pc_i,
   input  wire  [vaddr_width_p-1:0] expected_npc_i,
   input  wire                      mmu_cmd_ready_i,
   input  wire                      credits_full_i,
   input  wire                      credits_empty_i,
   input  wire                      flush_i,
   input  wire                      mem3_miss_i,

   output logic                     dispatch_v_o,
   output logic                     roll_o,
   output logic                     poison_iss_o,
   output logic                     poison_isd_o,
   output logic                     poison_ex1_o,
   output logic                     poison_ex2_o
   );

   logic [reg_addr_width_c-1:0] isd_rs1_addr, isd_rs2_addr;
   logic isd_irs1_v, isd_irs2_v, isd_frs1_v, isd_frs2_v, isd_fence_v, isd_mem_v;

   logic [reg_addr_width_c-1:0] rd_addr;
   logic mul_iwb_v, mem_iwb_v, mem_fwb_v, fp_fwb_v, mem_v, serial_v;

   logic [dep_stages_c-1:0][reg_addr_width_c-1:0] dep_rd_addr;
   logic [dep_stages_c-1:0] dep_mul_iwb_v, dep_mem_iwb_v, dep_mem_fwb_v;
   logic [dep_stages_c-1:0] dep_fp_fwb_v, dep_mem_v, dep_serial_v;
   logic                     ex1_v;
   logic [vaddr_width_p-1:0] ex1_pc;

   // Detector feedback into the pipeline
   logic dispatch_v, poison_isd, poison_ex1, poison_ex2;

   hzd_issue_decode u_decode (
      .isd_instr_i   (isd_instr_i),
      .isd_v_i       (isd_v_i),
      .isd_rs1_addr_o(isd_rs1_addr),
      .isd_rs2_addr_o(isd_rs2_addr),
      .isd_irs1_v_o  (isd_irs1_v),
      .isd_irs2_v_o  (isd_irs2_v),
      .isd_frs1_v_o  (isd_frs1_v),
      .isd_frs2_v_o  (isd_frs2_v),
      .isd_fence_v_o (isd_fence_v),
      .isd_mem_v_o   (isd_mem_v),
      .rd_addr_o     (rd_addr),
      .mul_iwb_v_o   (mul_iwb_v),
      .mem_iwb_v_o   (mem_iwb_v),
      .mem_fwb_v_o   (mem_fwb_v),
      .fp_fwb_v_o    (fp_fwb_v),
      .mem_v_o       (mem_v),
      .serial_v_o    (serial_v)
   );

   hzd_dep_pipe #(.vaddr_width_p(vaddr_width_p)) u_dep_pipe (
      .clk_i          (clk_i),
      .reset_i        (reset_i),
      .isd_v_i        (isd_v_i),
      .isd_pc_i       (isd_pc_i),
      .dispatch_v_i   (dispatch_v),
      .poison_isd_i   (poison_isd),
      .poison_ex1_i   (poison_ex1),
      .poison_ex2_i   (poison_ex2),
      .rd_addr_i      (rd_addr),
      .mul_iwb_v_i    (mul_iwb_v),
      .mem_iwb_v_i    (mem_iwb_v),
      .mem_fwb_v_i    (mem_fwb_v),
      .fp_fwb_v_i     (fp_fwb_v),
      .mem_v_i        (mem_v),
      .serial_v_i     (serial_v),
      .dep_rd_addr_o  (dep_rd_addr),
      .dep_mul_iwb_v_o(dep_mul_iwb_v),
      .dep_mem_iwb_v_o(dep_mem_iwb_v),
      .dep_mem_fwb_v_o(dep_mem_fwb_v),
      .dep_fp_fwb_v_o (dep_fp_fwb_v),
      .dep_mem_v_o    (dep_mem_v),
      .dep_serial_v_o (dep_serial_v),
      .ex1_v_o        (ex1_v),
      .ex1_pc_o       (ex1_pc)
   );

   hzd_detector #(.vaddr_width_p(vaddr_width_p)) u_detector (
      .clk_i           (clk_i),
      .reset_i         (reset_i),
      .isd_rs1_addr_i  (isd_rs1_addr),
      .isd_rs2_addr_i  (isd_rs2_addr),
      .isd_irs1_v_i    (isd_irs1_v),
      .isd_irs2_v_i    (isd_irs2_v),
      .isd_frs1_v_i    (isd_frs1_v),
      .isd_frs2_v_i    (isd_frs2_v),
      .isd_fence_v_i   (isd_fence_v),
      .isd_mem_v_i     (isd_mem_v),
      .dep_rd_addr_i   (dep_rd_addr),
      .dep_mul_iwb_v_i (dep_mul_iwb_v),
      .dep_mem_iwb_v_i (dep_mem_iwb_v),
      .dep_mem_fwb_v_i (dep_mem_fwb_v),
      .dep_fp_fwb_v_i  (dep_fp_fwb_v),
      .dep_mem_v_i     (dep_mem_v),
      .dep_serial_v_i  (dep_serial_v),
      .ex1_v_i         (ex1_v),
      .ex1_pc_i        (ex1_pc),
      .expected_npc_i  (expected_npc_i),
      .mmu_cmd_ready_i (mmu_cmd_ready_i),
      .credits_full_i  (credits_full_i),
      .credits_empty_i (credits_empty_i),
      .flush_i         (flush_i),
      .mem3_miss_i     (mem3_miss_i),
      .chk_dispatch_v_o(dispatch_v),
      .chk_roll_o      (roll_o),
      .chk_poison_iss_o(poison_iss_o),
      .chk_poison_isd_o(poison_isd),
      .chk_poison_ex1_o(poison_ex1),
      .chk_poison_ex2_o(poison_ex2)
   );

   assign dispatch_v_o = dispatch_v;
   assign poison_isd_o = poison_isd;
   assign poison_ex1_o = poison_ex1;
   assign poison_ex2_o = poison_ex2;

endmodule

`default_nettype wire

// File: verilog/hzd_dep_pipe.sv
/* Dependency pipeline
   Tracks writeback records of dispatched instructions through ex1, ex2, iwb and fwb */
`timescale 1ns/1ps
`default_nettype none

module hzd_dep_pipe
   import hzd_pkg::*;
   #(parameter int vaddr_width_p = 32)
   (
   input  wire                                            clk_i,
   input  wire                                            reset_i,

   input  wire                                            isd_v_i,
   input  wire  [vaddr_width_p-1:0]                       isd_pc_i,
   input  wire                                            dispatch_v_i,
   input  wire                                            poison_isd_i,
   input  wire                                            poison_ex1_i,
   input  wire                                            poison_ex2_i,

   // New record from decode
   input  wire  [reg_addr_width_c-1:0]                    rd_addr_i,
   input  wire                                            mul_iwb_v_i,
   input  wire                                            mem_iwb_v_i,
   input  wire                                            mem_fwb_v_i,
   input  wire                                            fp_fwb_v_i,
   input  wire                                            mem_v_i,
   input  wire                                            serial_v_i,

   output logic [dep_stages_c-1:0][reg_addr_width_c-1:0]  dep_rd_addr_o,
   output logic [dep_stages_c-1:0]                        dep_mul_iwb_v_o,
   output logic [dep_stages_c-1:0]                        dep_mem_iwb_v_o,
   output logic [dep_stages_c-1:0]                        dep_mem_fwb_v_o,
   output logic [dep_stages_c-1:0]                        dep_fp_fwb_v_o,
   output logic [dep_stages_c-1:0]                        dep_mem_v_o,
   output logic [dep_stages_c-1:0]                        dep_serial_v_o,
   output logic                                           ex1_v_o,
   output logic [vaddr_width_p-1:0]                       ex1_pc_o
   );

   localparam int flag_width_lp = 6;

   logic                        ins_v;
   logic [flag_width_lp-1:0]    flag_new;
   logic [dep_stages_c-2:0]     pass_v;
   logic [flag_width_lp-1:0]    flag_q [dep_stages_c];
   logic [reg_addr_width_c-1:0] rd_q   [dep_stages_c];
   logic                        ex1_v_q;
   logic [vaddr_width_p-1:0]    ex1_pc_q;

   // Only a dispatched, unpoisoned instruction enters ex1
   assign ins_v = isd_v_i & dispatch_v_i & ~poison_isd_i;

   assign flag_new = {serial_v_i, mem_v_i, fp_fwb_v_i, mem_fwb_v_i, mem_iwb_v_i, mul_iwb_v_i};

   // Stage s survives the move into s+1 unless it was poisoned
   assign pass_v[stage_ex1_c] = ~poison_ex1_i;
   assign pass_v[stage_ex2_c] = ~poison_ex2_i;
   assign pass_v[stage_iwb_c] = 1'b1;

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         for (int s = 0; s < dep_stages_c; s++)
         begin
            flag_q[s] <= '0;
         end
         ex1_v_q <= 1'b0;
      end
      else
      begin
         flag_q[stage_ex1_c] <= ins_v ? flag_new : '0;
         for (int s = 1; s < dep_stages_c; s++)
         begin
            flag_q[s] <= pass_v[s-1] ? flag_q[s-1] : '0;
         end
         ex1_v_q <= ins_v;
      end
   end

   // Destination addresses and the ex1 pc move alongside the flags
   always_ff @(posedge clk_i)
   begin
      rd_q[stage_ex1_c] <= rd_addr_i;
      for (int s = 1; s < dep_stages_c; s++)
      begin
         rd_q[s] <= rd_q[s-1];
      end
      ex1_pc_q <= isd_pc_i;
   end

   always_comb
   begin
      for (int s = 0; s < dep_stages_c; s++)
      begin
         dep_rd_addr_o[s]   = rd_q[s];
         dep_mul_iwb_v_o[s] = flag_q[s][0];
         dep_mem_iwb_v_o[s] = flag_q[s][1];
         dep_mem_fwb_v_o[s] = flag_q[s][2];
         dep_fp_fwb_v_o[s]  = flag_q[s][3];
         dep_mem_v_o[s]     = flag_q[s][4];
         dep_serial_v_o[s]  = flag_q[s][5];
      end
   end

   assign ex1_v_o  = ex1_v_q;
   assign ex1_pc_o = ex1_pc_q;

endmodule

`default_nettype wire

// File: verilog/hzd_detector.sv
/* Hazard detector
   Combinational check of data and structural hazards, mispredicts, flushes and misses */
`timescale 1ns/1ps
`default_nettype none

module hzd_detector
   import hzd_pkg::*;
   #(parameter int vaddr_width_p = 32)
   (
   input  wire                                            clk_i,
   input  wire                                            reset_i,

   // Issue side
   input  wire  [reg_addr_width_c-1:0]                    isd_rs1_addr_i,
   input  wire  [reg_addr_width_c-1:0]                    isd_rs2_addr_i,
   input  wire                                            isd_irs1_v_i,
   input  wire                                            isd_irs2_v_i,
   input  wire                                            isd_frs1_v_i,
   input  wire                                            isd_frs2_v_i,
   input  wire                                            isd_fence_v_i,
   input  wire                                            isd_mem_v_i,

   // In-flight records
   input  wire  [dep_stages_c-1:0][reg_addr_width_c-1:0]  dep_rd_addr_i,
   input  wire  [dep_stages_c-1:0]                        dep_mul_iwb_v_i,
   input  wire  [dep_stages_c-1:0]                        dep_mem_iwb_v_i,
   input  wire  [dep_stages_c-1:0]                        dep_mem_fwb_v_i,
   input  wire  [dep_stages_c-1:0]                        dep_fp_fwb_v_i,
   input  wire  [dep_stages_c-1:0]                        dep_mem_v_i,
   input  wire  [dep_stages_c-1:0]                        dep_serial_v_i,
   input  wire                                            ex1_v_i,
   input  wire  [vaddr_width_p-1:0]                       ex1_pc_i,

   input  wire  [vaddr_width_p-1:0]                       expected_npc_i,
   input  wire                                            mmu_cmd_ready_i,
   input  wire                                            credits_full_i,
   input  wire                                            credits_empty_i,
   input  wire                                            flush_i,
   input  wire                                            mem3_miss_i,

   output logic                                           chk_dispatch_v_o,
   output logic                                           chk_roll_o,
   output logic                                           chk_poison_iss_o,
   output logic                                           chk_poison_isd_o,
   output logic                                           chk_poison_ex1_o,
   output logic                                           chk_poison_ex2_o
   );

   // fwb results are always forwardable, so only ex1 to iwb are compared
   logic [dep_stages_c-2:0] rs1_match;
   logic [dep_stages_c-2:0] rs2_match;
   logic [dep_stages_c-2:0] int_prod;
   logic [dep_stages_c-2:0] fp_prod;
   logic irs1_haz_v, irs2_haz_v, frs1_haz_v, frs2_haz_v;
   logic mem_in_pipe_v, fence_haz_v, serial_haz_v;
   logic data_haz_v, struct_haz_v, mispredict_v, kill_v;

   always_comb
   begin
      for (int i = 0; i < dep_stages_c - 1; i++)
      begin
         rs1_match[i] = (isd_rs1_addr_i != '0) & (isd_rs1_addr_i == dep_rd_addr_i[i]);
         rs2_match[i] = (isd_rs2_addr_i != '0) & (isd_rs2_addr_i == dep_rd_addr_i[i]);
      end

      // Producers whose result cannot yet be forwarded
      int_prod[stage_ex1_c] = dep_mul_iwb_v_i[stage_ex1_c] | dep_mem_iwb_v_i[stage_ex1_c];
      int_prod[stage_ex2_c] = dep_mem_iwb_v_i[stage_ex2_c];
      int_prod[stage_iwb_c] = 1'b0;

      fp_prod[stage_ex1_c] = dep_mem_fwb_v_i[stage_ex1_c] | dep_fp_fwb_v_i[stage_ex1_c];
      fp_prod[stage_ex2_c] = dep_mem_fwb_v_i[stage_ex2_c] | dep_fp_fwb_v_i[stage_ex2_c];
      fp_prod[stage_iwb_c] = dep_fp_fwb_v_i[stage_iwb_c];

      irs1_haz_v = isd_irs1_v_i & (|(rs1_match & int_prod));
      irs2_haz_v = isd_irs2_v_i & (|(rs2_match & int_prod));
      frs1_haz_v = isd_frs1_v_i & (|(rs1_match & fp_prod));
      frs2_haz_v = isd_frs2_v_i & (|(rs2_match & fp_prod));
      data_haz_v = irs1_haz_v | irs2_haz_v | frs1_haz_v | frs2_haz_v;

      // Fences wait for outstanding memory traffic to drain
      mem_in_pipe_v = |dep_mem_v_i[stage_iwb_c:stage_ex1_c];
      fence_haz_v   = (isd_fence_v_i & (~credits_empty_i | mem_in_pipe_v))
                      | (isd_mem_v_i & credits_full_i);
      serial_haz_v  = |dep_serial_v_i;
      struct_haz_v  = ~mmu_cmd_ready_i | fence_haz_v | serial_haz_v;

      mispredict_v = ex1_v_i & (ex1_pc_i != expected_npc_i);
   end

   assign kill_v = flush_i | mem3_miss_i;

   assign chk_dispatch_v_o = ~(data_haz_v | struct_haz_v);
   assign chk_roll_o       = mem3_miss_i;

   // A mispredict squashes everything younger than ex1, and ex1 itself
   assign chk_poison_iss_o = mispredict_v | kill_v;
   assign chk_poison_isd_o = mispredict_v | kill_v;
   assign chk_poison_ex1_o = mispredict_v | kill_v;
   assign chk_poison_ex2_o = kill_v;

endmodule

`default_nettype wire

// File: verilog/hzd_issue_decode.sv
/* Issue decode
   Classifies the instruction at issue into source reads and a writeback record */
`timescale 1ns/1ps
`default_nettype none

module hzd_issue_decode
   import hzd_pkg::*;
   (
   input  wire hzd_instr_u                 isd_instr_i,
   input  wire                             isd_v_i,

   output logic [reg_addr_width_c-1:0]     isd_rs1_addr_o,
   output logic [reg_addr_width_c-1:0]     isd_rs2_addr_o,
   output logic                            isd_irs1_v_o,
   output logic                            isd_irs2_v_o,
   output logic                            isd_frs1_v_o,
   output logic                            isd_frs2_v_o,
   output logic                            isd_fence_v_o,
   output logic                            isd_mem_v_o,

   // Record for the dependency pipeline
   output logic [reg_addr_width_c-1:0]     rd_addr_o,
   output logic                            mul_iwb_v_o,
   output logic                            mem_iwb_v_o,
   output logic                            mem_fwb_v_o,
   output logic                            fp_fwb_v_o,
   output logic                            mem_v_o,
   output logic                            serial_v_o
   );

   logic load_v;
   logic load_fp_v;
   logic store_v;
   logic op_v;
   logic op_fp_v;
   logic fence_v;
   logic system_v;
   logic mul_v;
   logic wr_v;

   // Opcode classes, all qualified by a valid instruction
   assign load_v    = isd_v_i & (isd_instr_i.r.opcode == op_load_c);
   assign load_fp_v = isd_v_i & (isd_instr_i.r.opcode == op_load_fp_c);
   assign store_v   = isd_v_i & (isd_instr_i.s.opcode == op_store_c);
   assign op_v      = isd_v_i & (isd_instr_i.r.opcode == op_op_c);
   assign op_fp_v   = isd_v_i & (isd_instr_i.r.opcode == op_op_fp_c);
   assign fence_v   = isd_v_i & (isd_instr_i.r.opcode == op_fence_c);
   assign system_v  = isd_v_i & (isd_instr_i.r.opcode == op_system_c);

   assign mul_v = op_v & (isd_instr_i.r.funct7 == funct7_muldiv_c);

   assign isd_rs1_addr_o = isd_instr_i.r.rs1;
   assign isd_rs2_addr_o = isd_instr_i.r.rs2;

   assign isd_irs1_v_o  = load_v | load_fp_v | store_v | op_v | system_v;
   assign isd_irs2_v_o  = store_v | op_v;
   assign isd_frs1_v_o  = op_fp_v;
   assign isd_frs2_v_o  = op_fp_v;
   assign isd_fence_v_o = fence_v;
   assign isd_mem_v_o   = load_v | load_fp_v | store_v;

   // Store words carry imm_lo in the rd slot, so no destination is recorded
   assign rd_addr_o = store_v ? '0 : isd_instr_i.r.rd;

   // Writes to register 0 are dropped
   assign wr_v = (rd_addr_o != '0);

   assign mul_iwb_v_o = mul_v & wr_v;
   assign mem_iwb_v_o = load_v & wr_v;
   assign mem_fwb_v_o = load_fp_v & wr_v;
   assign fp_fwb_v_o  = op_fp_v & wr_v;
   assign mem_v_o     = isd_mem_v_o;
   assign serial_v_o  = system_v;

endmodule

`default_nettype wire

// File: verilog/hzd_pkg.sv
/* Hazard control package
   Opcodes, register and stage sizes, and the two views of an instruction word */
`default_nettype none

package hzd_pkg;

   localparam int reg_addr_width_c = 5;
   localparam int dep_stages_c     = 4;

   // Slots in the dependency vectors
   localparam int stage_ex1_c = 0;
   localparam int stage_ex2_c = 1;
   localparam int stage_iwb_c = 2;
   localparam int stage_fwb_c = 3;

   localparam logic [6:0] op_load_c    = 7'b0000011;
   localparam logic [6:0] op_load_fp_c = 7'b0000111;
   localparam logic [6:0] op_store_c   = 7'b0100011;
   localparam logic [6:0] op_op_c      = 7'b0110011;
   localparam logic [6:0] op_op_fp_c   = 7'b1010011;
   localparam logic [6:0] op_fence_c   = 7'b0001111;
   localparam logic [6:0] op_system_c  = 7'b1110011;

   // funct7 of the M extension within OP
   localparam logic [6:0] funct7_muldiv_c = 7'b0000001;

   typedef struct packed {
      logic [6:0]                  funct7;
      logic [reg_addr_width_c-1:0] rs2;
      logic [reg_addr_width_c-1:0] rs1;
      logic [2:0]                  funct3;
      logic [reg_addr_width_c-1:0] rd;
      logic [6:0]                  opcode;
   } hzd_instr_r_s;

   // Bits 11:7 hold the low immediate here instead of rd
   typedef struct packed {
      logic [6:0]                  imm_hi;
      logic [reg_addr_width_c-1:0] rs2;
      logic [reg_addr_width_c-1:0] rs1;
      logic [2:0]                  funct3;
      logic [4:0]                  imm_lo;
      logic [6:0]                  opcode;
   } hzd_instr_s_s;

   typedef union packed {
      hzd_instr_r_s r;
      hzd_instr_s_s s;
   } hzd_instr_u;

endpackage

`default_nettype wire
